//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int addr_w = 6;
    localparam int data_w = 16;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;

    // Operand field, mode bit on top of a 3-bit address
    typedef logic [3:0] field_t;
    localparam int mode_bit = 3;

    // Codes not listed here are fetched and skipped
    typedef enum logic [3:0] {
        op_mov  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_in   = 4'd7,
        op_out  = 4'd8,
        op_stop = 4'd15
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_mul
    } alu_op_t;

    // First instruction lives right after the eight operand words
    localparam addr_t pc_start = 6'd8;

    // Instruction word layout
    localparam int op_hi = 15;
    localparam int op_lo = 12;
    localparam int x_hi  = 11;
    localparam int x_lo  = 8;
    localparam int y_hi  = 7;
    localparam int y_lo  = 4;
    localparam int z_hi  = 3;
    localparam int z_lo  = 0;

endpackage

//--- hw/alu.sv
module alu import cpu_pkg::*; (
    input  alu_op_t op,
    input  data_t   a,
    input  data_t   b,
    output data_t   result
);

    // Results wrap to the data width, product keeps its low half
    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            default: result = a * b;
        endcase
    end

endmodule

//--- hw/mem_port.sv
module mem_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  write,
    input  addr_t addr,
    input  data_t wdata,
    output logic  done,
    output data_t rdata,
    output logic  mem_req_valid,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    input  logic  mem_req_ready,
    input  logic  mem_rsp_valid,
    input  data_t mem_rdata
);

    logic accept;
    logic rd_pending;
    logic rd_done;

    assign accept = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
            rd_pending    <= 1'b0;
            rd_done       <= 1'b0;
        end else begin
            if (start)
                mem_req_valid <= 1'b1;
            else if (accept)
                mem_req_valid <= 1'b0;

            // Only reads wait for a response
            if (accept && !mem_we)
                rd_pending <= 1'b1;
            else if (mem_rsp_valid)
                rd_pending <= 1'b0;

            rd_done <= rd_pending && mem_rsp_valid;
        end
    end

    // Request fields stay put until the memory takes them
    always_ff @(posedge clk) begin
        if (start) begin
            mem_we    <= write;
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
        if (rd_pending && mem_rsp_valid)
            rdata <= mem_rdata;
    end

    // A write ends at the transfer, a read one cycle after its response
    assign done = (accept && mem_we) || rd_done;

endmodule

//--- hw/io_port.sv
module io_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_start,
    input  logic  out_start,
    input  data_t out_word,
    output logic  in_done,
    output logic  out_done,
    output data_t in_word,
    input  logic  in_valid,
    input  data_t in_data,
    output logic  in_ready,
    output logic  out_valid,
    output data_t out_data,
    input  logic  out_ready
);

    logic in_xfer;
    logic out_xfer;

    assign in_xfer  = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready  <= 1'b0;
            in_done   <= 1'b0;
            out_valid <= 1'b0;
            out_done  <= 1'b0;
        end else begin
            // Ready only while an IN instruction waits for its word
            if (in_start)
                in_ready <= 1'b1;
            else if (in_xfer)
                in_ready <= 1'b0;
            in_done <= in_xfer;

            if (out_start)
                out_valid <= 1'b1;
            else if (out_xfer)
                out_valid <= 1'b0;
            out_done <= out_xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer)
            in_word <= in_data;
        // Held until the consumer takes it
        if (out_start)
            out_data <= out_word;
    end

endmodule

//--- hw/cpu_datapath.sv
module cpu_datapath import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ir_load,
    input  logic       pc_inc,
    input  logic       x_load,
    input  logic       y_load,
    input  logic       z_load,
    input  logic       acc_load,
    input  logic       mar_load,
    input  logic       x_sel,
    input  logic       y_sel,
    input  logic       z_sel,
    input  logic [1:0] mar_sel,
    input  logic       acc_from_in,
    input  logic       wdata_sel,
    input  alu_op_t    alu_op,
    input  data_t      rdata,
    input  data_t      in_word,
    output addr_t      mar,
    output opcode_t    opcode,
    output field_t     field_x,
    output field_t     field_y,
    output field_t     field_z,
    output data_t      acc,
    output data_t      wdata
);

    data_t ir;
    addr_t pc;
    addr_t x_addr;
    addr_t y_addr;
    addr_t z_addr;
    addr_t ind_addr;
    addr_t mar_next;
    data_t alu_result;

    assign opcode  = opcode_t'(ir[op_hi:op_lo]);
    assign field_x = ir[x_hi:x_lo];
    assign field_y = ir[y_hi:y_lo];
    assign field_z = ir[z_hi:z_lo];

    // Pointer word read during indirect resolution
    assign ind_addr = rdata[addr_w-1:0];

    always_comb begin
        case (mar_sel)
            2'd0:    mar_next = pc;
            2'd1:    mar_next = x_addr;
            2'd2:    mar_next = y_addr;
            default: mar_next = z_addr;
        endcase
    end

    // MAR starts on the first instruction so fetch can begin at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= pc_start;
            mar <= pc_start;
        end else begin
            if (pc_inc)
                pc <= pc + addr_t'(1);
            if (mar_load)
                mar <= mar_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load)
            ir <= rdata;
        if (x_load)
            x_addr <= x_sel ? ind_addr : addr_t'(field_x[mode_bit-1:0]);
        if (y_load)
            y_addr <= y_sel ? ind_addr : addr_t'(field_y[mode_bit-1:0]);
        if (z_load)
            z_addr <= z_sel ? ind_addr : addr_t'(field_z[mode_bit-1:0]);
        if (acc_load)
            acc <= acc_from_in ? in_word : rdata;
    end

    // ACC holds M[Y], the last read word is M[Z]
    alu alu_inst (
        .op     (alu_op),
        .a      (acc),
        .b      (rdata),
        .result (alu_result)
    );

    assign wdata = wdata_sel ? alu_result : acc;

endmodule

//--- hw/cpu_control.sv
module cpu_control import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  opcode_t    opcode,
    input  field_t     field_x,
    input  field_t     field_y,
    input  field_t     field_z,
    input  logic       mem_done,
    input  logic       in_done,
    input  logic       out_done,
    output logic       ir_load,
    output logic       pc_inc,
    output logic       x_load,
    output logic       y_load,
    output logic       z_load,
    output logic       acc_load,
    output logic       mar_load,
    output logic       x_sel,
    output logic       y_sel,
    output logic       z_sel,
    output logic [1:0] mar_sel,
    output logic       acc_from_in,
    output alu_op_t    alu_op,
    output logic       mem_start,
    output logic       mem_write,
    output logic       wdata_sel,
    output logic       in_start,
    output logic       out_start,
    output logic       halted
);

    typedef enum logic [4:0] {
        s_fetch,
        s_fetch_wait,
        s_decode,
        s_res,
        s_res_go,
        s_res_wait,
        s_ops,
        s_rd_a,
        s_rd_a_wait,
        s_rd_b,
        s_rd_b_wait,
        s_write,
        s_write_wait,
        s_in_wait,
        s_out,
        s_out_wait,
        s_halt
    } state_t;

    state_t     state;
    state_t     state_next;
    // Operand being resolved: 3 is z, 2 is y, 1 is x, same as the MAR select
    logic [1:0] res_idx;
    logic [1:0] idx_next;
    logic       is_arith;
    logic       res_ind;

    assign is_arith = opcode inside {op_add, op_sub, op_mul};

    // Only fields the opcode actually uses get resolved
    always_comb begin
        case (res_idx)
            2'd3:    res_ind = is_arith && field_z[mode_bit];
            2'd2:    res_ind = (is_arith || opcode == op_mov) && field_y[mode_bit];
            default: res_ind = field_x[mode_bit];
        endcase
    end

    always_comb begin
        case (opcode)
            op_sub:  alu_op = alu_sub;
            op_mul:  alu_op = alu_mul;
            default: alu_op = alu_add;
        endcase
    end

    assign x_sel       = (state == s_res_wait);
    assign y_sel       = (state == s_res_wait);
    assign z_sel       = (state == s_res_wait);
    assign acc_from_in = (state == s_in_wait);
    assign mem_write   = (state == s_write);
    assign wdata_sel   = is_arith;
    assign halted      = (state == s_halt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= s_fetch;
            res_idx <= 2'd3;
        end else begin
            state   <= state_next;
            res_idx <= idx_next;
        end
    end

    always_comb begin
        state_next = state;
        idx_next   = res_idx;
        ir_load    = 1'b0;
        pc_inc     = 1'b0;
        x_load     = 1'b0;
        y_load     = 1'b0;
        z_load     = 1'b0;
        acc_load   = 1'b0;
        mar_load   = 1'b0;
        mar_sel    = 2'd0;
        mem_start  = 1'b0;
        in_start   = 1'b0;
        out_start  = 1'b0;

        case (state)
            s_fetch: begin
                mem_start  = 1'b1;
                pc_inc     = 1'b1;
                state_next = s_fetch_wait;
            end
            s_fetch_wait: begin
                if (mem_done) begin
                    ir_load    = 1'b1;
                    state_next = s_decode;
                end
            end
            s_decode: begin
                // Direct addresses first, indirect ones overwrite them later
                x_load   = 1'b1;
                y_load   = 1'b1;
                z_load   = 1'b1;
                idx_next = 2'd3;
                case (opcode)
                    op_mov: begin
                        if (field_z != '0) begin
                            mar_load   = 1'b1;
                            state_next = s_fetch;
                        end else begin
                            state_next = s_res;
                        end
                    end
                    op_add, op_sub, op_mul, op_in, op_out:
                        state_next = s_res;
                    op_stop:
                        state_next = s_halt;
                    default: begin
                        mar_load   = 1'b1;
                        state_next = s_fetch;
                    end
                endcase
            end
            s_res: begin
                if (res_ind) begin
                    mar_sel    = res_idx;
                    mar_load   = 1'b1;
                    state_next = s_res_go;
                end else if (res_idx == 2'd1) begin
                    state_next = s_ops;
                end else begin
                    idx_next = res_idx - 2'd1;
                end
            end
            s_res_go: begin
                mem_start  = 1'b1;
                state_next = s_res_wait;
            end
            s_res_wait: begin
                if (mem_done) begin
                    case (res_idx)
                        2'd3:    z_load = 1'b1;
                        2'd2:    y_load = 1'b1;
                        default: x_load = 1'b1;
                    endcase
                    if (res_idx == 2'd1) begin
                        state_next = s_ops;
                    end else begin
                        idx_next   = res_idx - 2'd1;
                        state_next = s_res;
                    end
                end
            end
            s_ops: begin
                case (opcode)
                    op_in: begin
                        in_start   = 1'b1;
                        state_next = s_in_wait;
                    end
                    op_out: begin
                        mar_sel    = 2'd1;
                        mar_load   = 1'b1;
                        state_next = s_rd_a;
                    end
                    default: begin
                        mar_sel    = 2'd2;
                        mar_load   = 1'b1;
                        state_next = s_rd_a;
                    end
                endcase
            end
            s_rd_a: begin
                mem_start  = 1'b1;
                state_next = s_rd_a_wait;
            end
            s_rd_a_wait: begin
                if (mem_done) begin
                    acc_load = 1'b1;
                    mar_load = 1'b1;
                    if (opcode == op_out) begin
                        mar_load   = 1'b0;
                        state_next = s_out;
                    end else if (is_arith) begin
                        mar_sel    = 2'd3;
                        state_next = s_rd_b;
                    end else begin
                        mar_sel    = 2'd1;
                        state_next = s_write;
                    end
                end
            end
            s_rd_b: begin
                mem_start  = 1'b1;
                state_next = s_rd_b_wait;
            end
            s_rd_b_wait: begin
                // Second operand stays in the memory port for the ALU
                if (mem_done) begin
                    mar_sel    = 2'd1;
                    mar_load   = 1'b1;
                    state_next = s_write;
                end
            end
            s_write: begin
                mem_start  = 1'b1;
                state_next = s_write_wait;
            end
            s_write_wait: begin
                if (mem_done) begin
                    mar_load   = 1'b1;
                    state_next = s_fetch;
                end
            end
            s_in_wait: begin
                if (in_done) begin
                    acc_load   = 1'b1;
                    mar_sel    = 2'd1;
                    mar_load   = 1'b1;
                    state_next = s_write;
                end
            end
            s_out: begin
                out_start  = 1'b1;
                state_next = s_out_wait;
            end
            s_out_wait: begin
                if (out_done) begin
                    mar_load   = 1'b1;
                    state_next = s_fetch;
                end
            end
            default: begin
                // Halted until reset
            end
        endcase
    end

endmodule

//--- hw/cpu_top.sv
module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    output logic           mem_req_valid,
    output logic           mem_we,
    output cpu_pkg::addr_t mem_addr,
    output cpu_pkg::data_t mem_wdata,
    input  logic           mem_req_ready,
    input  logic           mem_rsp_valid,
    input  cpu_pkg::data_t mem_rdata,
    input  logic           in_valid,
    input  cpu_pkg::data_t in_data,
    output logic           in_ready,
    output logic           out_valid,
    output cpu_pkg::data_t out_data,
    input  logic           out_ready,
    output logic           halted
);

    logic              ir_load;
    logic              pc_inc;
    logic              x_load;
    logic              y_load;
    logic              z_load;
    logic              acc_load;
    logic              mar_load;
    logic              x_sel;
    logic              y_sel;
    logic              z_sel;
    logic [1:0]        mar_sel;
    logic              acc_from_in;
    logic              wdata_sel;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::opcode_t  opcode;
    cpu_pkg::field_t   field_x;
    cpu_pkg::field_t   field_y;
    cpu_pkg::field_t   field_z;
    logic              mem_start;
    logic              mem_write;
    logic              mem_done;
    logic              in_start;
    logic              in_done;
    logic              out_start;
    logic              out_done;
    cpu_pkg::addr_t    mar;
    cpu_pkg::data_t    acc;
    cpu_pkg::data_t    wdata;
    cpu_pkg::data_t    rdata;
    cpu_pkg::data_t    in_word;

    cpu_control cpu_control_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .field_x     (field_x),
        .field_y     (field_y),
        .field_z     (field_z),
        .mem_done    (mem_done),
        .in_done     (in_done),
        .out_done    (out_done),
        .ir_load     (ir_load),
        .pc_inc      (pc_inc),
        .x_load      (x_load),
        .y_load      (y_load),
        .z_load      (z_load),
        .acc_load    (acc_load),
        .mar_load    (mar_load),
        .x_sel       (x_sel),
        .y_sel       (y_sel),
        .z_sel       (z_sel),
        .mar_sel     (mar_sel),
        .acc_from_in (acc_from_in),
        .alu_op      (alu_op),
        .mem_start   (mem_start),
        .mem_write   (mem_write),
        .wdata_sel   (wdata_sel),
        .in_start    (in_start),
        .out_start   (out_start),
        .halted      (halted)
    );

    cpu_datapath cpu_datapath_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ir_load     (ir_load),
        .pc_inc      (pc_inc),
        .x_load      (x_load),
        .y_load      (y_load),
        .z_load      (z_load),
        .acc_load    (acc_load),
        .mar_load    (mar_load),
        .x_sel       (x_sel),
        .y_sel       (y_sel),
        .z_sel       (z_sel),
        .mar_sel     (mar_sel),
        .acc_from_in (acc_from_in),
        .wdata_sel   (wdata_sel),
        .alu_op      (alu_op),
        .rdata       (rdata),
        .in_word     (in_word),
        .mar         (mar),
        .opcode      (opcode),
        .field_x     (field_x),
        .field_y     (field_y),
        .field_z     (field_z),
        .acc         (acc),
        .wdata       (wdata)
    );

    mem_port mem_port_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (mem_start),
        .write         (mem_write),
        .addr          (mar),
        .wdata         (wdata),
        .done          (mem_done),
        .rdata         (rdata),
        .mem_req_valid (mem_req_valid),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata)
    );

    // OUT words leave from ACC
    io_port io_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_start  (in_start),
        .out_start (out_start),
        .out_word  (acc),
        .in_done   (in_done),
        .out_done  (out_done),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

//--- sim/cpu_asserts.sv
module cpu_asserts import cpu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  mem_req_valid,
    input logic  mem_we,
    input addr_t mem_addr,
    input data_t mem_wdata,
    input logic  mem_req_ready,
    input logic  mem_rsp_valid
);

    logic rd_open;

    // Read accepted but not yet answered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_open <= 1'b0;
        else if (mem_req_valid && mem_req_ready && !mem_we)
            rd_open <= 1'b1;
        else if (mem_rsp_valid)
            rd_open <= 1'b0;
    end

    // Bus idle as reset ends, first fetch follows within two cycles
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !mem_req_valid ##[1:2] mem_req_valid)
        else $error("memory request wrong around the end of reset");

    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed before it was accepted");

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        rd_open |-> !mem_req_valid)
        else $error("new memory request while a read is outstanding");

endmodule

bind mem_port cpu_asserts cpu_asserts_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid)
);

//--- sim/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

    localparam int num_progs = 20;
    localparam int prog_len  = 24;
    localparam int max_steps = 64;
    // Budget of 60 cycles per instruction plus reset and halt checks
    localparam int watchdog_time = num_progs * (max_steps * 60 + 200) * 40;

    logic  clk;
    logic  rst_n;
    logic  mem_req_valid;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_req_ready;
    logic  mem_rsp_valid;
    data_t mem_rdata;
    logic  in_valid;
    data_t in_data;
    logic  in_ready;
    logic  out_valid;
    data_t out_data;
    logic  out_ready;
    logic  halted;

    int    seed;
    int    errors;
    int    checks;
    int    in_idx;
    int    in_used;
    data_t init_mem [64];
    data_t mem      [64];
    data_t ref_mem  [64];
    data_t in_words [64];
    addr_t exp_waddr [$];
    data_t exp_wdata [$];
    data_t exp_out   [$];

    cpu_top cpu_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_halt(string name, logic got, logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Indirect operands point through the low six bits of a memory word
    function automatic addr_t eff_addr(field_t f);
        if (f[3])
            return ref_mem[addr_t'(f[2:0])][addr_w-1:0];
        return addr_t'(f[2:0]);
    endfunction

    task automatic make_program();
        logic [31:0] rnd;
        logic [3:0]  op;
        data_t       word;
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            init_mem[addr_t'(i)] = rnd[15:0];
            in_words[addr_t'(i)] = rnd[31:16];
        end
        for (int i = 0; i < prog_len; i++) begin
            rnd = $random(seed);
            // Mostly kept operations, a few skipped codes
            case (rnd[19:16])
                4'd0, 4'd1, 4'd2: op = op_mov;
                4'd3, 4'd4:       op = op_add;
                4'd5, 4'd6:       op = op_sub;
                4'd7, 4'd8:       op = op_mul;
                4'd9, 4'd10:      op = op_in;
                4'd11, 4'd12:     op = op_out;
                default: op = (rnd[22:20] < 3'd3) ? 4'd4 + {1'b0, rnd[22:20]}
                                                  : 4'd6 + {1'b0, rnd[22:20]};
            endcase
            word = {op, rnd[11:0]};
            // Half the moves get a zero z field so they execute
            if (op == op_mov && rnd[23])
                word[3:0] = 4'd0;
            init_mem[addr_t'(8 + i)] = word;
        end
        rnd = $random(seed);
        op = op_stop;
        init_mem[addr_t'(8 + prog_len)] = {op, rnd[11:0]};
    endtask

    task automatic run_model(output logic ok);
        addr_t pc;
        data_t ir;
        addr_t ex;
        addr_t ey;
        addr_t ez;
        data_t val;
        logic  wr;
        ok = 1'b0;
        pc = pc_start;
        in_used = 0;
        exp_waddr.delete();
        exp_wdata.delete();
        exp_out.delete();
        for (int i = 0; i < 64; i++)
            ref_mem[addr_t'(i)] = init_mem[addr_t'(i)];
        for (int s = 0; s < max_steps && !ok; s++) begin
            ir = ref_mem[pc];
            pc = pc + addr_t'(1);
            // All operands resolve before the instruction writes anything
            ex = eff_addr(ir[11:8]);
            ey = eff_addr(ir[7:4]);
            ez = eff_addr(ir[3:0]);
            wr = 1'b0;
            val = '0;
            case (ir[15:12])
                op_mov: begin
                    wr  = (ir[3:0] == 4'd0);
                    val = ref_mem[ey];
                end
                op_add: begin
                    wr  = 1'b1;
                    val = ref_mem[ey] + ref_mem[ez];
                end
                op_sub: begin
                    wr  = 1'b1;
                    val = ref_mem[ey] - ref_mem[ez];
                end
                op_mul: begin
                    wr  = 1'b1;
                    val = ref_mem[ey] * ref_mem[ez];
                end
                op_in: begin
                    wr  = 1'b1;
                    val = in_words[addr_t'(in_used)];
                    in_used = in_used + 1;
                end
                op_out:  exp_out.push_back(ref_mem[ex]);
                op_stop: ok = 1'b1;
                default: begin
                end
            endcase
            if (wr) begin
                exp_waddr.push_back(ex);
                exp_wdata.push_back(val);
                ref_mem[ex] = val;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // Memory and I/O partners, sampled mid-cycle and driven just after the edge
    initial begin : bus_model
        logic [31:0] rnd;
        logic        live;
        logic        req_fire;
        logic        req_we;
        addr_t       req_addr;
        data_t       req_wdata;
        logic        in_fire;
        logic        out_fire;
        data_t       out_word;
        logic [2:0]  rd_cnt;
        addr_t       rd_addr;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        in_valid      = 1'b0;
        in_data       = '0;
        out_ready     = 1'b0;
        rd_cnt        = 3'd0;
        rd_addr       = '0;
        in_idx        = 0;
        forever begin
            @(negedge clk);
            live      = rst_n;
            req_fire  = mem_req_valid && mem_req_ready;
            req_we    = mem_we;
            req_addr  = mem_addr;
            req_wdata = mem_wdata;
            in_fire   = in_valid && in_ready;
            out_fire  = out_valid && out_ready;
            out_word  = out_data;
            @(posedge clk);
            #2;
            mem_rsp_valid = 1'b0;
            if (!live) begin
                for (int i = 0; i < 64; i++)
                    mem[addr_t'(i)] = init_mem[addr_t'(i)];
                rd_cnt        = 3'd0;
                in_idx        = 0;
                in_valid      = 1'b0;
                mem_req_ready = 1'b0;
                out_ready     = 1'b0;
            end else begin
                if (req_fire && req_we) begin
                    if (exp_waddr.size() == 0) begin
                        errors = errors + 1;
                        $display("at %0t: unexpected memory write to %0h", $time, req_addr);
                    end else begin
                        check_addr("mem_addr", req_addr, exp_waddr.pop_front());
                        check_data("mem_wdata", req_wdata, exp_wdata.pop_front());
                    end
                    mem[req_addr] = req_wdata;
                end else if (req_fire) begin
                    // Read answered 1 to 4 cycles after the transfer
                    rnd     = $random(seed);
                    rd_addr = req_addr;
                    rd_cnt  = {1'b0, rnd[1:0]} + 3'd1;
                end
                if (rd_cnt != 3'd0) begin
                    rd_cnt = rd_cnt - 3'd1;
                    if (rd_cnt == 3'd0) begin
                        mem_rsp_valid = 1'b1;
                        mem_rdata     = mem[rd_addr];
                    end
                end
                rnd = $random(seed);
                mem_req_ready = (rnd[1:0] != 2'b00);

                if (in_fire)
                    in_idx = in_idx + 1;
                // An offered input word stays until it is taken
                if (!in_valid || in_fire) begin
                    rnd = $random(seed);
                    in_valid = (rnd[1:0] == 2'b00);
                end
                in_data = in_words[addr_t'(in_idx)];

                if (out_fire) begin
                    if (exp_out.size() == 0) begin
                        errors = errors + 1;
                        $display("at %0t: unexpected output word %0h", $time, out_word);
                    end else begin
                        check_data("out_data", out_word, exp_out.pop_front());
                    end
                end
                rnd = $random(seed);
                out_ready = rnd[0];
            end
        end
    end

    initial begin : main_flow
        logic ok;
        rst_n  = 1'b0;
        seed   = 32'h39b29269;
        errors = 0;
        checks = 0;
        for (int p = 0; p < num_progs; p++) begin
            // Drop programs that overwrite their own STOP and never halt
            ok = 1'b0;
            while (!ok) begin
                make_program();
                run_model(ok);
            end
            apply_reset();
            @(negedge clk);
            check_halt("halted", halted, 1'b0);
            while (halted !== 1'b1)
                @(negedge clk);
            if (exp_waddr.size() != 0 || exp_out.size() != 0) begin
                errors = errors + 1;
                $display("at %0t: program %0d halted with %0d writes and %0d outputs missing",
                         $time, p, exp_waddr.size(), exp_out.size());
            end
            if (in_idx != in_used) begin
                errors = errors + 1;
                $display("at %0t: program %0d took %0d input words instead of %0d",
                         $time, p, in_idx, in_used);
            end
            repeat (100) begin
                @(negedge clk);
                check_halt("halted", halted, 1'b1);
                if (mem_req_valid) begin
                    errors = errors + 1;
                    $display("at %0t: memory request issued after halt", $time);
                end
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_time);
        $display("timeout: the CPU did not reach STOP within the time limit");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- all.f
hw/cpu_pkg.sv
hw/alu.sv
hw/mem_port.sv
hw/io_port.sv
hw/cpu_datapath.sv
hw/cpu_control.sv
hw/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench prints its pass line

verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_sim \
    && ./obj_dir/cpu_sim | tee /dev/stderr | grep "NO ERRORS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
